// ==== filelist.f ====
+incdir+common
common/mem_bus_pkg.sv
common/mem_perf_pkg.sv
common/mem_bus_if.sv
smem/smem_router.sv
smem/shared_mem.sv
verilog/mem_arb.sv
verilog/mem_perf.sv
verilog/mem_unit.sv
bench/mem_unit_props.sv
bench/mem_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mem_unit

export_include_dirs:
  - common

sources:
  - files:
      - common/mem_bus_pkg.sv
      - common/mem_perf_pkg.sv
      - common/mem_bus_if.sv
      - smem/smem_router.sv
      - smem/shared_mem.sv
      - verilog/mem_arb.sv
      - verilog/mem_perf.sv
      - verilog/mem_unit.sv
  - target: test
    files:
      - bench/mem_unit_props.sv
      - bench/mem_unit_tb.sv

// ==== bench/mem_unit_tb.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

module mem_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;
    import mem_perf_pkg::*;

    localparam int N_TESTS = 13;
    localparam int NTAGS   = 1 << `CORE_TAG_WIDTH;

    typedef struct {
        string       name;
        logic        dport;
        mem_op_e     op;
        mem_addr_t   addr;
        mem_data_t   data;
        mem_byteen_t byteen;
        core_tag_t   tag;
        mem_data_t   exp;
        logic        chain;
    } test_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        icache_req_valid = 1'b0;
    mem_addr_t   icache_req_addr = '0;
    core_tag_t   icache_req_tag = '0;
    logic        icache_req_ready;
    logic        icache_rsp_valid;
    mem_data_t   icache_rsp_data;
    core_tag_t   icache_rsp_tag;
    logic        icache_rsp_ready = 1'b1;
    logic        dcache_req_valid = 1'b0;
    mem_op_e     dcache_req_op = MEM_READ;
    mem_addr_t   dcache_req_addr = '0;
    mem_data_t   dcache_req_data = '0;
    mem_byteen_t dcache_req_byteen = '0;
    core_tag_t   dcache_req_tag = '0;
    logic        dcache_req_ready;
    logic        dcache_rsp_valid;
    mem_data_t   dcache_rsp_data;
    core_tag_t   dcache_rsp_tag;
    logic        dcache_rsp_ready = 1'b1;
    logic        mem_req_valid;
    mem_op_e     mem_req_op;
    mem_addr_t   mem_req_addr;
    mem_data_t   mem_req_data;
    mem_byteen_t mem_req_byteen;
    mem_tag_t    mem_req_tag;
    logic        mem_req_ready = 1'b0;
    logic        mem_rsp_valid = 1'b0;
    mem_data_t   mem_rsp_data = '0;
    mem_tag_t    mem_rsp_tag = '0;
    logic        mem_rsp_ready;
    mem_perf_t   perf;

    test_t       tests [N_TESTS];
    int          n_tests = 0;
    int          n_checks = 0;
    int          errors = 0;
    int          outstanding = 0;
    int          cycle = 0;
    int          seed = 32'h090f_e6d3;
    int          ext_reads = 0;
    int          ext_writes = 0;
    int          ext_stalls = 0;
    int          ext_pending = 0;
    int          ext_latency = 0;
    logic        rsp_taken = 1'b0;
    mem_perf_t   snap;
    mem_data_t   ext_mem [mem_addr_t];
    mem_data_t   rd_data_q [$];
    mem_tag_t    rd_tag_q [$];
    int          rd_due_q [$];
    logic        exp_valid [2][NTAGS] = '{default: 1'b0};
    mem_data_t   exp_data [2][NTAGS];
    string       exp_name [2][NTAGS];

    mem_unit i_mem_unit (.*);

    always #2 clk = ~clk;

    function automatic mem_data_t fill_word(mem_addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic mem_data_t read_ext(mem_addr_t a);
        return ext_mem.exists(a) ? ext_mem[a] : fill_word(a);
    endfunction

    function automatic mem_data_t merge_bytes(mem_data_t old_w, mem_data_t new_w, mem_byteen_t be);
        mem_data_t w;
        w = old_w;
        for (int b = 0; b < `MEM_BYTEEN_WIDTH; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic in_window(mem_addr_t a);
        return (a >= `SMEM_BASE) && (a < `SMEM_BASE + 4 * `SMEM_WORDS);
    endfunction

    task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_test(input string name, input logic dport, input mem_op_e op,
                            input mem_addr_t addr, input mem_data_t data, input mem_byteen_t be,
                            input core_tag_t tag, input mem_data_t exp, input logic chain);
        tests[n_tests] = '{name, dport, op, addr, data, be, tag, exp, chain};
        n_tests++;
    endtask

    task automatic issue(input int i);
        if (tests[i].op == MEM_READ || in_window(tests[i].addr)) begin
            exp_valid[tests[i].dport][tests[i].tag] = 1'b1;
            exp_data[tests[i].dport][tests[i].tag]  = tests[i].exp;
            exp_name[tests[i].dport][tests[i].tag]  = tests[i].name;
            outstanding++;
        end
        if (tests[i].dport) begin
            dcache_req_op     = tests[i].op;
            dcache_req_addr   = tests[i].addr;
            dcache_req_data   = tests[i].data;
            dcache_req_byteen = tests[i].byteen;
            dcache_req_tag    = tests[i].tag;
            dcache_req_valid  = 1'b1;
        end else begin
            icache_req_addr  = tests[i].addr;
            icache_req_tag   = tests[i].tag;
            icache_req_valid = 1'b1;
        end
        do @(negedge clk); while (!(tests[i].dport ? dcache_req_ready : icache_req_ready));
        @(posedge clk);
        #1;
        icache_req_valid = 1'b0;
        dcache_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (outstanding != 0 || mem_req_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic take_rsp(input logic p, input core_tag_t tag, input mem_data_t data);
        if (!exp_valid[p][tag]) begin
            $display("Unexpected response on the %s port with tag %0d", p ? "dcache" : "icache",
                     tag);
            errors++;
        end else begin
            check(exp_name[p][tag], exp_data[p][tag], data);
            exp_valid[p][tag] = 1'b0;
            outstanding--;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && icache_rsp_valid && icache_rsp_ready) begin
            take_rsp(1'b0, icache_rsp_tag, icache_rsp_data);
        end
        if (!reset && dcache_rsp_valid && dcache_rsp_ready) begin
            take_rsp(1'b1, dcache_rsp_tag, dcache_rsp_data);
        end
    end

    // External memory, sampled where its inputs are stable
    always @(negedge clk) begin
        if (!reset) begin
            ext_latency += ext_pending;
            if (mem_req_valid && !mem_req_ready) begin
                ext_stalls++;
            end
            if (mem_req_valid && mem_req_ready && mem_req_op == MEM_WRITE) begin
                ext_mem[mem_req_addr] = merge_bytes(read_ext(mem_req_addr), mem_req_data,
                                                    mem_req_byteen);
                ext_writes++;
            end else if (mem_req_valid && mem_req_ready) begin
                rd_data_q.push_back(read_ext(mem_req_addr));
                rd_tag_q.push_back(mem_req_tag);
                rd_due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 4));
                ext_reads++;
                ext_pending++;
            end
            rsp_taken = mem_rsp_valid && mem_rsp_ready;
            if (rsp_taken) begin
                ext_pending--;
            end
        end
    end

    // Reads answered in order once their delay has passed
    always begin
        @(posedge clk);
        #1;
        cycle++;
        mem_req_ready    = ($unsigned($random(seed)) % 4) != 0;
        icache_rsp_ready = ($unsigned($random(seed)) % 4) != 0;
        dcache_rsp_ready = ($unsigned($random(seed)) % 4) != 0;
        if (rsp_taken) begin
            void'(rd_data_q.pop_front());
            void'(rd_tag_q.pop_front());
            void'(rd_due_q.pop_front());
            rsp_taken = 1'b0;
        end
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = rd_data_q[0];
            mem_rsp_tag   = rd_tag_q[0];
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

    initial begin
        repeat (50 * N_TESTS) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", 50 * N_TESTS);
        $display("Checks: %0d, errors: %0d", n_checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        add_test("fetch", 0, MEM_READ, 32'h1000, '0, 4'hF, 1, fill_word(32'h1000), 0);
        add_test("ext_wr", 1, MEM_WRITE, 32'h2000, 32'hDEAD_BEEF, 4'hF, 2, '0, 0);
        add_test("ext_rd", 1, MEM_READ, 32'h2000, '0, 4'hF, 3, 32'hDEAD_BEEF, 0);
        add_test("smem_wr", 1, MEM_WRITE, `SMEM_BASE + 32'h10, 32'h1234_5678, 4'hF, 4,
                 32'h1234_5678, 0);
        add_test("smem_rd", 1, MEM_READ, `SMEM_BASE + 32'h10, '0, 4'hF, 5, 32'h1234_5678, 0);
        add_test("smem_part_wr", 1, MEM_WRITE, `SMEM_BASE + 32'h10, 32'hAABB_CCDD, 4'b0101, 6,
                 merge_bytes(32'h1234_5678, 32'hAABB_CCDD, 4'b0101), 0);
        add_test("smem_part_rd", 1, MEM_READ, `SMEM_BASE + 32'h10, '0, 4'hF, 7,
                 merge_bytes(32'h1234_5678, 32'hAABB_CCDD, 4'b0101), 0);
        // Back to back, matched by tag
        add_test("mix_fetch_a", 0, MEM_READ, 32'h3000, '0, 4'hF, 8, fill_word(32'h3000), 1);
        add_test("mix_data_a", 1, MEM_READ, 32'h2000, '0, 4'hF, 9, 32'hDEAD_BEEF, 1);
        add_test("mix_fetch_b", 0, MEM_READ, 32'h3004, '0, 4'hF, 10, fill_word(32'h3004), 1);
        add_test("mix_data_b", 1, MEM_READ, 32'h4000, '0, 4'hF, 11, fill_word(32'h4000), 1);
        add_test("mix_fetch_c", 0, MEM_READ, 32'h3008, '0, 4'hF, 12, fill_word(32'h3008), 1);
        add_test("mix_data_c", 1, MEM_READ, `SMEM_BASE + 32'h10, '0, 4'hF, 13,
                 merge_bytes(32'h1234_5678, 32'hAABB_CCDD, 4'b0101), 0);

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check("reset_outputs", 0, {icache_rsp_valid, dcache_rsp_valid, mem_req_valid});
        check("reset_perf", 0, perf.reads | perf.writes | perf.stalls | perf.latency);

        for (int i = 0; i < n_tests; i++) begin
            snap = perf;
            issue(i);
            if (!tests[i].chain) begin
                wait_idle();
                if (in_window(tests[i].addr) && (i == 0 || !tests[i-1].chain)) begin
                    check({tests[i].name, "_perf_reads"}, snap.reads, perf.reads);
                    check({tests[i].name, "_perf_writes"}, snap.writes, perf.writes);
                end
            end
        end

        wait_idle();
        @(negedge clk);
        check("perf_reads", ext_reads, perf.reads);
        check("perf_writes", ext_writes, perf.writes);
        check("perf_stalls", ext_stalls, perf.stalls);
        check("perf_latency", ext_latency, perf.latency);
        $display("Checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mem_unit_props.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

module mem_unit_props #(
    parameter int PAYLOAD_W = 1
) (
    input wire                       clk,
    input wire                       reset,
    input wire                       valid,
    input wire                       ready,
    input wire [PAYLOAD_W-1:0]       payload,
    input wire                       i_fire,
    input wire                       d_fire,
    input wire [`CORE_TAG_WIDTH-1:0] i_tag,
    input wire [`CORE_TAG_WIDTH-1:0] d_tag,
    input wire [`MEM_TAG_WIDTH-1:0]  out_tag
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled transfer keeps valid and its payload
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        valid && !ready |=> valid && $stable(payload))
        else $error("Transfer dropped or changed while stalled");

    // Source bit 0 marks the fetch port, 1 the data port
    tag_src_i: assert property (@(posedge clk) disable iff (reset)
        i_fire |=> out_tag == {$past(i_tag), 1'b0})
        else $error("Fetch request registered without its fetch-port tag");

    tag_src_d: assert property (@(posedge clk) disable iff (reset)
        d_fire |=> out_tag == {$past(d_tag), 1'b1})
        else $error("Data request registered without its data-port tag");

endmodule

bind mem_arb mem_unit_props #(
    .PAYLOAD_W(1 + `MEM_ADDR_WIDTH + `MEM_DATA_WIDTH + `MEM_BYTEEN_WIDTH + `MEM_TAG_WIDTH)
) i_arb_props (
    .clk     (clk),
    .reset   (reset),
    .valid   (mem.req_valid),
    .ready   (mem.req_ready),
    .payload ({mem.req_op, mem.req_addr, mem.req_data, mem.req_byteen, mem.req_tag}),
    .i_fire  (src_i.req_valid && src_i.req_ready),
    .d_fire  (src_d.req_valid && src_d.req_ready),
    .i_tag   (src_i.req_tag),
    .d_tag   (src_d.req_tag),
    .out_tag (mem.req_tag)
);

bind shared_mem mem_unit_props #(
    .PAYLOAD_W(`MEM_DATA_WIDTH + `CORE_TAG_WIDTH)
) i_smem_props (
    .clk     (clk),
    .reset   (reset),
    .valid   (bus.rsp_valid),
    .ready   (bus.rsp_ready),
    .payload ({bus.rsp_data, bus.rsp_tag}),
    .i_fire  (1'b0),
    .d_fire  (1'b0),
    .i_tag   ('0),
    .d_tag   ('0),
    .out_tag ('0)
);

`default_nettype wire

// ==== verilog/mem_unit.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

module mem_unit (
    input  wire                      clk,
    input  wire                      reset,

    input  wire                      icache_req_valid,
    input  mem_bus_pkg::mem_addr_t   icache_req_addr,
    input  mem_bus_pkg::core_tag_t   icache_req_tag,
    output logic                     icache_req_ready,
    output logic                     icache_rsp_valid,
    output mem_bus_pkg::mem_data_t   icache_rsp_data,
    output mem_bus_pkg::core_tag_t   icache_rsp_tag,
    input  wire                      icache_rsp_ready,

    input  wire                      dcache_req_valid,
    input  mem_bus_pkg::mem_op_e     dcache_req_op,
    input  mem_bus_pkg::mem_addr_t   dcache_req_addr,
    input  mem_bus_pkg::mem_data_t   dcache_req_data,
    input  mem_bus_pkg::mem_byteen_t dcache_req_byteen,
    input  mem_bus_pkg::core_tag_t   dcache_req_tag,
    output logic                     dcache_req_ready,
    output logic                     dcache_rsp_valid,
    output mem_bus_pkg::mem_data_t   dcache_rsp_data,
    output mem_bus_pkg::core_tag_t   dcache_rsp_tag,
    input  wire                      dcache_rsp_ready,

    output logic                     mem_req_valid,
    output mem_bus_pkg::mem_op_e     mem_req_op,
    output mem_bus_pkg::mem_addr_t   mem_req_addr,
    output mem_bus_pkg::mem_data_t   mem_req_data,
    output mem_bus_pkg::mem_byteen_t mem_req_byteen,
    output mem_bus_pkg::mem_tag_t    mem_req_tag,
    input  wire                      mem_req_ready,
    input  wire                      mem_rsp_valid,
    input  mem_bus_pkg::mem_data_t   mem_rsp_data,
    input  mem_bus_pkg::mem_tag_t    mem_rsp_tag,
    output logic                     mem_rsp_ready,

    output mem_perf_pkg::mem_perf_t  perf
);
    import mem_bus_pkg::*;

    mem_bus_if #(.TAG_WIDTH(`CORE_TAG_WIDTH)) ibus ();
    mem_bus_if #(.TAG_WIDTH(`CORE_TAG_WIDTH)) dbus ();
    mem_bus_if #(.TAG_WIDTH(`CORE_TAG_WIDTH)) dmem_bus ();
    mem_bus_if #(.TAG_WIDTH(`CORE_TAG_WIDTH)) smem_bus ();
    mem_bus_if #(.TAG_WIDTH(`MEM_TAG_WIDTH))  xbus ();

    // Fetch port is read-only
    assign ibus.req_valid    = icache_req_valid;
    assign ibus.req_op       = MEM_READ;
    assign ibus.req_addr     = icache_req_addr;
    assign ibus.req_data     = '0;
    assign ibus.req_byteen   = '1;
    assign ibus.req_tag      = icache_req_tag;
    assign icache_req_ready  = ibus.req_ready;
    assign icache_rsp_valid  = ibus.rsp_valid;
    assign icache_rsp_data   = ibus.rsp_data;
    assign icache_rsp_tag    = ibus.rsp_tag;
    assign ibus.rsp_ready    = icache_rsp_ready;

    assign dbus.req_valid    = dcache_req_valid;
    assign dbus.req_op       = dcache_req_op;
    assign dbus.req_addr     = dcache_req_addr;
    assign dbus.req_data     = dcache_req_data;
    assign dbus.req_byteen   = dcache_req_byteen;
    assign dbus.req_tag      = dcache_req_tag;
    assign dcache_req_ready  = dbus.req_ready;
    assign dcache_rsp_valid  = dbus.rsp_valid;
    assign dcache_rsp_data   = dbus.rsp_data;
    assign dcache_rsp_tag    = dbus.rsp_tag;
    assign dbus.rsp_ready    = dcache_rsp_ready;

    assign mem_req_valid     = xbus.req_valid;
    assign mem_req_op        = xbus.req_op;
    assign mem_req_addr      = xbus.req_addr;
    assign mem_req_data      = xbus.req_data;
    assign mem_req_byteen    = xbus.req_byteen;
    assign mem_req_tag       = xbus.req_tag;
    assign xbus.req_ready    = mem_req_ready;
    assign xbus.rsp_valid    = mem_rsp_valid;
    assign xbus.rsp_data     = mem_rsp_data;
    assign xbus.rsp_tag      = mem_rsp_tag;
    assign mem_rsp_ready     = xbus.rsp_ready;

    smem_router i_smem_router (
        .core (dbus),
        .smem (smem_bus),
        .dmem (dmem_bus)
    );

    shared_mem i_shared_mem (
        .clk   (clk),
        .reset (reset),
        .bus   (smem_bus)
    );

    mem_arb i_mem_arb (
        .clk   (clk),
        .reset (reset),
        .src_i (ibus),
        .src_d (dmem_bus),
        .mem   (xbus)
    );

    mem_perf i_mem_perf (
        .clk       (clk),
        .reset     (reset),
        .req_valid (xbus.req_valid),
        .req_ready (xbus.req_ready),
        .req_op    (xbus.req_op),
        .rsp_valid (xbus.rsp_valid),
        .rsp_ready (xbus.rsp_ready),
        .perf      (perf)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_perf.sv ====
`default_nettype none

module mem_perf (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     req_valid,
    input  wire                     req_ready,
    input  mem_bus_pkg::mem_op_e    req_op,
    input  wire                     rsp_valid,
    input  wire                     rsp_ready,
    output mem_perf_pkg::mem_perf_t perf
);
    import mem_bus_pkg::*;
    import mem_perf_pkg::*;

    mem_perf_t perf_q;
    perf_ctr_t pending_q;
    logic      rd_fire;
    logic      wr_fire;
    logic      rsp_fire;

    assign rd_fire  = req_valid && req_ready && (req_op == MEM_READ);
    assign wr_fire  = req_valid && req_ready && (req_op == MEM_WRITE);
    assign rsp_fire = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_q    <= '0;
            pending_q <= '0;
        end else begin
            perf_q.reads   <= perf_q.reads + perf_ctr_t'(rd_fire);
            perf_q.writes  <= perf_q.writes + perf_ctr_t'(wr_fire);
            perf_q.stalls  <= perf_q.stalls + perf_ctr_t'(req_valid && !req_ready);
            // Every outstanding read adds one cycle of latency
            perf_q.latency <= perf_q.latency + pending_q;
            pending_q      <= pending_q + perf_ctr_t'(rd_fire) - perf_ctr_t'(rsp_fire);
        end
    end

    assign perf = perf_q;

endmodule

`default_nettype wire

// ==== verilog/mem_arb.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

module mem_arb (
    input wire        clk,
    input wire        reset,
    mem_bus_if.slave  src_i,
    mem_bus_if.slave  src_d,
    mem_bus_if.master mem
);
    import mem_bus_pkg::*;

    mem_src_e    last_grant_q;
    mem_src_e    grant_src;
    mem_src_e    rsp_src;
    logic        any_valid;
    logic        can_load;

    mem_op_e     sel_op;
    mem_addr_t   sel_addr;
    mem_data_t   sel_data;
    mem_byteen_t sel_byteen;
    core_tag_t   sel_tag;

    logic        out_valid_q;
    mem_op_e     out_op_q;
    mem_addr_t   out_addr_q;
    mem_data_t   out_data_q;
    mem_byteen_t out_byteen_q;
    mem_tag_t    out_tag_q;

    assign any_valid = src_i.req_valid || src_d.req_valid;
    assign can_load  = !out_valid_q || mem.req_ready;

    // Round robin, the last winner yields on a tie
    always_comb begin
        if (src_i.req_valid && src_d.req_valid) begin
            grant_src = (last_grant_q == SRC_ICACHE) ? SRC_DCACHE : SRC_ICACHE;
        end else if (src_d.req_valid) begin
            grant_src = SRC_DCACHE;
        end else begin
            grant_src = SRC_ICACHE;
        end
    end

    assign src_i.req_ready = can_load && (grant_src == SRC_ICACHE);
    assign src_d.req_ready = can_load && (grant_src == SRC_DCACHE);

    always_comb begin
        if (grant_src == SRC_DCACHE) begin
            sel_op     = src_d.req_op;
            sel_addr   = src_d.req_addr;
            sel_data   = src_d.req_data;
            sel_byteen = src_d.req_byteen;
            sel_tag    = src_d.req_tag;
        end else begin
            sel_op     = src_i.req_op;
            sel_addr   = src_i.req_addr;
            sel_data   = src_i.req_data;
            sel_byteen = src_i.req_byteen;
            sel_tag    = src_i.req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q  <= 1'b0;
            last_grant_q <= SRC_DCACHE;
        end else if (can_load) begin
            out_valid_q <= any_valid;
            if (any_valid) begin
                last_grant_q <= grant_src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && any_valid) begin
            out_op_q     <= sel_op;
            out_addr_q   <= sel_addr;
            out_data_q   <= sel_data;
            out_byteen_q <= sel_byteen;
            out_tag_q    <= {sel_tag, grant_src};
        end
    end

    assign mem.req_valid  = out_valid_q;
    assign mem.req_op     = out_op_q;
    assign mem.req_addr   = out_addr_q;
    assign mem.req_data   = out_data_q;
    assign mem.req_byteen = out_byteen_q;
    assign mem.req_tag    = out_tag_q;

    // Responses steered by the source bit
    assign rsp_src         = mem_src_e'(mem.rsp_tag[0]);
    assign src_i.rsp_valid = mem.rsp_valid && (rsp_src == SRC_ICACHE);
    assign src_d.rsp_valid = mem.rsp_valid && (rsp_src == SRC_DCACHE);
    assign src_i.rsp_data  = mem.rsp_data;
    assign src_d.rsp_data  = mem.rsp_data;
    assign src_i.rsp_tag   = mem.rsp_tag[`MEM_TAG_WIDTH-1:1];
    assign src_d.rsp_tag   = mem.rsp_tag[`MEM_TAG_WIDTH-1:1];
    assign mem.rsp_ready   = (rsp_src == SRC_DCACHE) ? src_d.rsp_ready : src_i.rsp_ready;

endmodule

`default_nettype wire

// ==== smem/shared_mem.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

module shared_mem (
    input wire       clk,
    input wire       reset,
    mem_bus_if.slave bus
);
    import mem_bus_pkg::*;

    localparam int IDX_W  = $clog2(`SMEM_WORDS);
    localparam int OFFS_W = $clog2(`MEM_BYTEEN_WIDTH);

    mem_data_t        ram [`SMEM_WORDS];
    logic [IDX_W-1:0] req_idx;
    logic             req_fire;
    mem_data_t        wr_word;
    logic             rsp_valid_q;
    mem_data_t        rsp_data_q;
    core_tag_t        rsp_tag_q;

    assign req_idx       = bus.req_addr[OFFS_W +: IDX_W];
    assign bus.req_ready = !rsp_valid_q || bus.rsp_ready;
    assign req_fire      = bus.req_valid && bus.req_ready;

    // Stored word merged with the enabled bytes
    always_comb begin
        wr_word = ram[req_idx];
        for (int b = 0; b < `MEM_BYTEEN_WIDTH; b++) begin
            if (bus.req_byteen[b]) begin
                wr_word[8*b +: 8] = bus.req_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (bus.req_op == MEM_WRITE) begin
                ram[req_idx] <= wr_word;
            end
            rsp_data_q <= (bus.req_op == MEM_WRITE) ? wr_word : ram[req_idx];
            rsp_tag_q  <= bus.req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (bus.rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_data  = rsp_data_q;
    assign bus.rsp_tag   = rsp_tag_q;

endmodule

`default_nettype wire

// ==== smem/smem_router.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

module smem_router (
    mem_bus_if.slave  core,
    mem_bus_if.master smem,
    mem_bus_if.master dmem
);
    import mem_bus_pkg::*;

    localparam mem_addr_t SMEM_LO = `SMEM_BASE;
    localparam mem_addr_t SMEM_HI = `SMEM_BASE + `MEM_BYTEEN_WIDTH * `SMEM_WORDS;

    logic in_smem;

    assign in_smem = (core.req_addr >= SMEM_LO) && (core.req_addr < SMEM_HI);

    // Payload goes to both sides, only one sees valid
    assign smem.req_valid  = core.req_valid && in_smem;
    assign smem.req_op     = core.req_op;
    assign smem.req_addr   = core.req_addr;
    assign smem.req_data   = core.req_data;
    assign smem.req_byteen = core.req_byteen;
    assign smem.req_tag    = core.req_tag;

    assign dmem.req_valid  = core.req_valid && !in_smem;
    assign dmem.req_op     = core.req_op;
    assign dmem.req_addr   = core.req_addr;
    assign dmem.req_data   = core.req_data;
    assign dmem.req_byteen = core.req_byteen;
    assign dmem.req_tag    = core.req_tag;

    assign core.req_ready  = in_smem ? smem.req_ready : dmem.req_ready;

    // Scratchpad has priority on the return path
    assign core.rsp_valid  = smem.rsp_valid || dmem.rsp_valid;
    assign core.rsp_data   = smem.rsp_valid ? smem.rsp_data : dmem.rsp_data;
    assign core.rsp_tag    = smem.rsp_valid ? smem.rsp_tag : dmem.rsp_tag;
    assign smem.rsp_ready  = core.rsp_ready;
    assign dmem.rsp_ready  = core.rsp_ready && !smem.rsp_valid;

endmodule

`default_nettype wire

// ==== common/mem_bus_if.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

interface mem_bus_if #(
    parameter int TAG_WIDTH = `CORE_TAG_WIDTH
);
    import mem_bus_pkg::*;

    logic                 req_valid;
    mem_op_e              req_op;
    mem_addr_t            req_addr;
    mem_data_t            req_data;
    mem_byteen_t          req_byteen;
    logic [TAG_WIDTH-1:0] req_tag;
    logic                 req_ready;

    logic                 rsp_valid;
    mem_data_t            rsp_data;
    logic [TAG_WIDTH-1:0] rsp_tag;
    logic                 rsp_ready;

    modport master (
        output req_valid, req_op, req_addr, req_data, req_byteen, req_tag, rsp_ready,
        input  req_ready, rsp_valid, rsp_data, rsp_tag
    );

    modport slave (
        input  req_valid, req_op, req_addr, req_data, req_byteen, req_tag, rsp_ready,
        output req_ready, rsp_valid, rsp_data, rsp_tag
    );

endinterface

`default_nettype wire

// ==== common/mem_perf_pkg.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

package mem_perf_pkg;

    typedef logic [`PERF_CTR_WIDTH-1:0] perf_ctr_t;

    // External memory statistics
    typedef struct packed {
        perf_ctr_t reads;
        perf_ctr_t writes;
        perf_ctr_t stalls;
        perf_ctr_t latency;
    } mem_perf_t;

endpackage

`default_nettype wire

// ==== common/mem_bus_pkg.sv ====
`default_nettype none

`include "mem_unit_macros.svh"

package mem_bus_pkg;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Lives in bit 0 of the external tag
    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } mem_src_e;

    typedef logic [`MEM_ADDR_WIDTH-1:0]   mem_addr_t;
    typedef logic [`MEM_DATA_WIDTH-1:0]   mem_data_t;
    typedef logic [`MEM_BYTEEN_WIDTH-1:0] mem_byteen_t;
    typedef logic [`CORE_TAG_WIDTH-1:0]   core_tag_t;
    typedef logic [`MEM_TAG_WIDTH-1:0]    mem_tag_t;

endpackage

`default_nettype wire

// ==== common/mem_unit_macros.svh ====
`ifndef MEM_UNIT_MACROS_SVH
`define MEM_UNIT_MACROS_SVH

// Bus widths
`define MEM_ADDR_WIDTH   32
`define MEM_DATA_WIDTH   32
`define MEM_BYTEEN_WIDTH 4

// Core tag, shared by the fetch and data ports
`define CORE_TAG_WIDTH 4

// External tag carries the arbiter source in bit 0
`define MEM_TAG_WIDTH (`CORE_TAG_WIDTH + 1)

// Shared-memory window, aligned to its own size
`define SMEM_BASE  32'hFF00_0000
`define SMEM_WORDS 64

// Performance counters
`define PERF_CTR_WIDTH 32

`endif
